// File: source/stream_geometry_pkg.sv
`default_nettype none

package stream_geometry_pkg;

  // input segment carries one 32-bit word per beat
  localparam int in_data_width = 32;
  localparam int in_keep_width = in_data_width / 8;

  // byte stream between the downsizer and the upsizer
  localparam int mid_data_width = 8;
  localparam int mid_keep_width = mid_data_width / 8;

  // output segment carries one 16-bit halfword per beat
  localparam int out_data_width = 16;
  localparam int out_keep_width = out_data_width / 8;

  // byte beats produced from one input word
  localparam int down_ratio = in_keep_width / mid_keep_width;

  // byte beats packed into one output beat
  localparam int up_ratio = out_keep_width / mid_keep_width;

endpackage

`default_nettype wire

// File: source/adapter_state_pkg.sv
`default_nettype none

package adapter_state_pkg;

  // position of a byte lane inside a wide beat
  typedef logic [1:0] lane_index_t;

  typedef enum logic [0:0] {
    down_idle,
    down_transfer_out
  } down_state_t;

  // up_transfer_out means a packed beat is waiting for the output stage
  typedef enum logic [1:0] {
    up_idle,
    up_transfer_in,
    up_transfer_out
  } up_state_t;

endpackage

`default_nettype wire

// File: source/axis_skid_buffer.sv
`default_nettype none

module axis_skid_buffer #(
  parameter int data_width = 8
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire [data_width-1:0]    in_tdata,
  input  wire [data_width/8-1:0]  in_tkeep,
  input  wire                     in_tvalid,
  input  wire                     in_tlast,
  input  wire                     in_tuser,
  output logic                    in_ready_early,
  output logic [data_width-1:0]   out_tdata,
  output logic [data_width/8-1:0] out_tkeep,
  output logic                    out_tvalid,
  output logic                    out_tlast,
  output logic                    out_tuser,
  input  wire                     out_tready
);

  logic [data_width-1:0]   spare_tdata;
  logic [data_width/8-1:0] spare_tkeep;
  logic                    spare_tvalid;
  logic                    spare_tlast;
  logic                    spare_tuser;

  // the adapter may present a beat next cycle if the output drains or the spare stays empty
  assign in_ready_early = out_tready || (!spare_tvalid && (!out_tvalid || !in_tvalid));

  always_ff @(posedge clk) begin
    if (rst) begin
      out_tvalid   <= 1'b0;
      out_tlast    <= 1'b0;
      out_tuser    <= 1'b0;
      spare_tvalid <= 1'b0;
    end else if (in_tvalid) begin
      if (out_tready || !out_tvalid) begin
        out_tdata  <= in_tdata;
        out_tkeep  <= in_tkeep;
        out_tvalid <= 1'b1;
        out_tlast  <= in_tlast;
        out_tuser  <= in_tuser;
      end else begin
        // output is stalled, so park the beat in the spare slot
        spare_tdata  <= in_tdata;
        spare_tkeep  <= in_tkeep;
        spare_tvalid <= 1'b1;
        spare_tlast  <= in_tlast;
        spare_tuser  <= in_tuser;
      end
    end else if (out_tready) begin
      out_tdata    <= spare_tdata;
      out_tkeep    <= spare_tkeep;
      out_tvalid   <= spare_tvalid;
      out_tlast    <= spare_tlast;
      out_tuser    <= spare_tuser;
      spare_tvalid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: source/axis_downsizer.sv
`default_nettype none

module axis_downsizer
  import stream_geometry_pkg::*, adapter_state_pkg::*;
(
  input  wire                        clk,
  input  wire                        rst,
  input  wire [in_data_width-1:0]    s_tdata,
  input  wire [in_keep_width-1:0]    s_tkeep,
  input  wire                        s_tvalid,
  input  wire                        s_tlast,
  input  wire                        s_tuser,
  output logic                       s_tready,
  output logic [mid_data_width-1:0]  m_tdata,
  output logic [mid_keep_width-1:0]  m_tkeep,
  output logic                       m_tvalid,
  output logic                       m_tlast,
  output logic                       m_tuser,
  input  wire                        m_tready
);

  down_state_t               state;
  down_state_t               state_next;
  lane_index_t               lane;
  lane_index_t               lane_next;
  lane_index_t               lane_sel;
  lane_index_t               lane_inc;
  logic                      s_tready_next;
  logic                      in_ready;
  logic                      in_ready_early;
  logic                      accept;
  logic                      final_lane;
  logic                      beat_valid;
  logic [in_data_width-1:0]  hold_data;
  logic [in_keep_width-1:0]  hold_keep;
  logic                      hold_last;
  logic                      hold_user;
  logic [in_data_width-1:0]  src_data;
  logic [in_keep_width-1:0]  src_keep;
  logic                      src_last;
  logic                      src_user;

  assign accept = s_tvalid && s_tready;

  // in idle, lane zero comes straight from the input bus
  assign src_data = (state == down_idle) ? s_tdata : hold_data;
  assign src_keep = (state == down_idle) ? s_tkeep : hold_keep;
  assign src_last = (state == down_idle) ? s_tlast : hold_last;
  assign src_user = (state == down_idle) ? s_tuser : hold_user;
  assign lane_sel = (state == down_idle) ? lane_index_t'(0) : lane;
  assign lane_inc = lane_sel + 1'b1;

  // keep is contiguous, so a clear bit in the next lane ends the word
  assign final_lane = (lane_sel == lane_index_t'(down_ratio - 1)) || !src_keep[lane_inc];

  always_comb begin
    state_next    = state;
    lane_next     = lane;
    s_tready_next = 1'b0;
    beat_valid    = 1'b0;
    case (state)
      down_idle: begin
        s_tready_next = 1'b1;
        if (accept) begin
          beat_valid = in_ready;
          lane_next  = (in_ready && !final_lane) ? lane_inc : lane_index_t'(0);
          if (!final_lane || !in_ready) begin
            s_tready_next = 1'b0;
            state_next    = down_transfer_out;
          end
        end
      end
      down_transfer_out: begin
        beat_valid = in_ready;
        if (in_ready) begin
          lane_next = lane_inc;
          if (final_lane) begin
            lane_next     = '0;
            s_tready_next = 1'b1;
            state_next    = down_idle;
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= down_idle;
      lane     <= '0;
      s_tready <= 1'b0;
      in_ready <= 1'b0;
    end else begin
      state    <= state_next;
      lane     <= lane_next;
      s_tready <= s_tready_next;
      in_ready <= in_ready_early;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      hold_data <= s_tdata;
      hold_keep <= s_tkeep;
      hold_last <= s_tlast;
      hold_user <= s_tuser;
    end
  end

  axis_skid_buffer #(
    .data_width(mid_data_width)
  ) i_skid_buffer (
    .clk           (clk),
    .rst           (rst),
    .in_tdata      (src_data[lane_sel*mid_data_width +: mid_data_width]),
    .in_tkeep      (src_keep[lane_sel]),
    .in_tvalid     (beat_valid),
    .in_tlast      (src_last && final_lane),
    .in_tuser      (src_user && final_lane),
    .in_ready_early(in_ready_early),
    .out_tdata     (m_tdata),
    .out_tkeep     (m_tkeep),
    .out_tvalid    (m_tvalid),
    .out_tlast     (m_tlast),
    .out_tuser     (m_tuser),
    .out_tready    (m_tready)
  );

endmodule

`default_nettype wire

// File: source/axis_upsizer.sv
`default_nettype none

module axis_upsizer
  import stream_geometry_pkg::*, adapter_state_pkg::*;
(
  input  wire                        clk,
  input  wire                        rst,
  input  wire [mid_data_width-1:0]   s_tdata,
  input  wire [mid_keep_width-1:0]   s_tkeep,
  input  wire                        s_tvalid,
  input  wire                        s_tlast,
  input  wire                        s_tuser,
  output logic                       s_tready,
  output logic [out_data_width-1:0]  m_tdata,
  output logic [out_keep_width-1:0]  m_tkeep,
  output logic                       m_tvalid,
  output logic                       m_tlast,
  output logic                       m_tuser,
  input  wire                        m_tready
);

  up_state_t                  state;
  up_state_t                  state_next;
  lane_index_t                lane;
  lane_index_t                lane_next;
  logic                       s_tready_next;
  logic                       in_ready;
  logic                       in_ready_early;
  logic                       accept;
  logic                       pair_done;
  logic                       beat_valid;
  logic                       beat_from_pair;
  logic [out_data_width-1:0]  pair_data;
  logic [out_keep_width-1:0]  pair_keep;
  logic [out_data_width-1:0]  temp_data;
  logic [out_keep_width-1:0]  temp_keep;
  logic                       temp_last;
  logic                       temp_user;

  assign accept    = s_tvalid && s_tready;
  assign pair_done = (lane == lane_index_t'(up_ratio - 1)) || s_tlast;

  // a pair restarts from zero, so a lone last byte leaves the high half clear
  always_comb begin
    pair_data = (lane == '0) ? '0 : temp_data;
    pair_keep = (lane == '0) ? '0 : temp_keep;
    pair_data[lane*mid_data_width +: mid_data_width] = s_tdata;
    pair_keep[lane*mid_keep_width +: mid_keep_width] = s_tkeep;
  end

  always_comb begin
    state_next     = state;
    lane_next      = lane;
    s_tready_next  = 1'b0;
    beat_valid     = 1'b0;
    beat_from_pair = 1'b0;
    case (state)
      up_idle, up_transfer_in: begin
        s_tready_next = 1'b1;
        if (accept) begin
          if (pair_done) begin
            lane_next      = '0;
            beat_from_pair = 1'b1;
            beat_valid     = in_ready;
            if (in_ready) begin
              state_next = up_idle;
            end else begin
              state_next    = up_transfer_out;
              s_tready_next = in_ready_early;
            end
          end else begin
            lane_next  = lane + 1'b1;
            state_next = up_transfer_in;
          end
        end
      end
      up_transfer_out: begin
        beat_valid    = in_ready;
        s_tready_next = in_ready_early;
        if (in_ready) begin
          if (!accept) begin
            s_tready_next = 1'b1;
            state_next    = up_idle;
          end else if (!pair_done) begin
            // first byte of the next pair arrives while the held beat leaves
            lane_next     = lane + 1'b1;
            s_tready_next = 1'b1;
            state_next    = up_transfer_in;
          end
        end
      end
      default: state_next = up_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= up_idle;
      lane     <= '0;
      s_tready <= 1'b0;
      in_ready <= 1'b0;
    end else begin
      state    <= state_next;
      lane     <= lane_next;
      s_tready <= s_tready_next;
      in_ready <= in_ready_early;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      temp_data <= pair_data;
      temp_keep <= pair_keep;
      temp_last <= s_tlast;
      temp_user <= s_tuser;
    end
  end

  axis_skid_buffer #(
    .data_width(out_data_width)
  ) i_skid_buffer (
    .clk           (clk),
    .rst           (rst),
    .in_tdata      (beat_from_pair ? pair_data : temp_data),
    .in_tkeep      (beat_from_pair ? pair_keep : temp_keep),
    .in_tvalid     (beat_valid),
    .in_tlast      (beat_from_pair ? s_tlast : temp_last),
    .in_tuser      (beat_from_pair ? s_tuser : temp_user),
    .in_ready_early(in_ready_early),
    .out_tdata     (m_tdata),
    .out_tkeep     (m_tkeep),
    .out_tvalid    (m_tvalid),
    .out_tlast     (m_tlast),
    .out_tuser     (m_tuser),
    .out_tready    (m_tready)
  );

endmodule

`default_nettype wire

// File: source/stream_resizer.sv
`default_nettype none

module stream_resizer
  import stream_geometry_pkg::*;
(
  input  wire                        clk,
  input  wire                        rst,
  input  wire [in_data_width-1:0]    s_tdata,
  input  wire [in_keep_width-1:0]    s_tkeep,
  input  wire                        s_tvalid,
  input  wire                        s_tlast,
  input  wire                        s_tuser,
  output logic                       s_tready,
  output logic [out_data_width-1:0]  m_tdata,
  output logic [out_keep_width-1:0]  m_tkeep,
  output logic                       m_tvalid,
  output logic                       m_tlast,
  output logic                       m_tuser,
  input  wire                        m_tready
);

  // byte stream between the two stages
  logic [mid_data_width-1:0] mid_tdata;
  logic [mid_keep_width-1:0] mid_tkeep;
  logic                      mid_tvalid;
  logic                      mid_tready;
  logic                      mid_tlast;
  logic                      mid_tuser;

  axis_downsizer i_downsizer (
    .clk     (clk),
    .rst     (rst),
    .s_tdata (s_tdata),
    .s_tkeep (s_tkeep),
    .s_tvalid(s_tvalid),
    .s_tlast (s_tlast),
    .s_tuser (s_tuser),
    .s_tready(s_tready),
    .m_tdata (mid_tdata),
    .m_tkeep (mid_tkeep),
    .m_tvalid(mid_tvalid),
    .m_tlast (mid_tlast),
    .m_tuser (mid_tuser),
    .m_tready(mid_tready)
  );

  axis_upsizer i_upsizer (
    .clk     (clk),
    .rst     (rst),
    .s_tdata (mid_tdata),
    .s_tkeep (mid_tkeep),
    .s_tvalid(mid_tvalid),
    .s_tlast (mid_tlast),
    .s_tuser (mid_tuser),
    .s_tready(mid_tready),
    .m_tdata (m_tdata),
    .m_tkeep (m_tkeep),
    .m_tvalid(m_tvalid),
    .m_tlast (m_tlast),
    .m_tuser (m_tuser),
    .m_tready(m_tready)
  );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clock_period = 100;
  localparam int reset_cycles = 3;

  initial begin
    clk = 1'b0;
    forever #(clock_period / 2) clk = ~clk;
  end

  // release reset on a falling edge so the first stimulus edge sees it low
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: verification/stream_resizer_tb.sv
`default_nettype none

module stream_resizer_tb
  import stream_geometry_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int frame_count = 200;
  localparam int max_frame_bytes = 16;
  localparam int calm_frames = 20;
  localparam int reset_cycles = 3;
  localparam int drain_cycles = 8;
  localparam int timeout_cycles = frame_count * max_frame_bytes * 4 * 4;
  localparam int beat_width = out_data_width + out_keep_width + 2;
  localparam logic [15:0] lfsr_seed = 16'd75;

  logic                      clk;
  logic                      rst;
  logic [in_data_width-1:0]  s_tdata;
  logic [in_keep_width-1:0]  s_tkeep;
  logic                      s_tvalid;
  logic                      s_tlast;
  logic                      s_tuser;
  logic                      s_tready;
  logic [out_data_width-1:0] m_tdata;
  logic [out_keep_width-1:0] m_tkeep;
  logic                      m_tvalid;
  logic                      m_tlast;
  logic                      m_tuser;
  logic                      m_tready;

  logic [15:0]               lfsr_state;
  logic [in_data_width-1:0]  word_data_q[$];
  logic [in_keep_width-1:0]  word_keep_q[$];
  logic                      word_last_q[$];
  logic                      word_user_q[$];
  // expected output beats packed as user, last, keep, data
  logic [beat_width-1:0]     exp_q[$];
  int                        calm_words;
  int                        calm_beats;
  int                        total_beats;
  int                        beats_seen;
  int                        cycle_count;

  tb_clock_gen i_clock_gen (
    .clk(clk),
    .rst(rst)
  );

  stream_resizer i_stream_resizer (
    .clk     (clk),
    .rst     (rst),
    .s_tdata (s_tdata),
    .s_tkeep (s_tkeep),
    .s_tvalid(s_tvalid),
    .s_tlast (s_tlast),
    .s_tuser (s_tuser),
    .s_tready(s_tready),
    .m_tdata (m_tdata),
    .m_tkeep (m_tkeep),
    .m_tvalid(m_tvalid),
    .m_tlast (m_tlast),
    .m_tuser (m_tuser),
    .m_tready(m_tready)
  );

  // taps 16, 14, 13 and 11 with one step per bit taken
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
      feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], feedback};
      value      = {value[30:0], feedback};
    end
    return value;
  endfunction

  function automatic string describe_beat(input logic [beat_width-1:0] beat);
    return $sformatf("data %h keep %b last %b user %b", beat[out_data_width-1:0],
                     beat[out_data_width +: out_keep_width], beat[beat_width-2],
                     beat[beat_width-1]);
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  // builds the input words and the expected 16-bit beats of every frame
  task automatic build_frames();
    logic [7:0]                frame_bytes[$];
    logic [in_data_width-1:0]  word;
    logic [in_keep_width-1:0]  keep;
    logic [out_data_width-1:0] half;
    logic [out_keep_width-1:0] half_keep;
    logic                      user;
    logic                      last;
    int                        len;
    for (int f = 0; f < frame_count; f++) begin
      len  = int'(random_bits(4)) + 1;
      user = random_bits(1) != 0;
      frame_bytes.delete();
      for (int i = 0; i < len; i++) begin
        frame_bytes.push_back(8'(random_bits(8)));
      end
      for (int i = 0; i < len; i += in_keep_width) begin
        word = '0;
        keep = '0;
        for (int lane = 0; lane < in_keep_width && i + lane < len; lane++) begin
          word[lane*8 +: 8] = frame_bytes[i+lane];
          keep[lane]        = 1'b1;
        end
        last = (i + in_keep_width >= len);
        word_data_q.push_back(word);
        word_keep_q.push_back(keep);
        word_last_q.push_back(last);
        word_user_q.push_back(last && user);
      end
      // bytes pair up low then high and a lone final byte leaves the high half zero
      for (int i = 0; i < len; i += out_keep_width) begin
        half      = '0;
        half_keep = '0;
        for (int lane = 0; lane < out_keep_width && i + lane < len; lane++) begin
          half[lane*8 +: 8] = frame_bytes[i+lane];
          half_keep[lane]   = 1'b1;
        end
        last = (i + out_keep_width >= len);
        exp_q.push_back({last && user, last, half_keep, half});
      end
      if (f < calm_frames) begin
        calm_words = word_data_q.size();
        calm_beats = exp_q.size();
      end
    end
    total_beats = exp_q.size();
  endtask

  always @(posedge clk) begin
    logic [beat_width-1:0] expected;
    logic [beat_width-1:0] actual;
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      abort_run($sformatf("timeout after %0d cycles with %0d of %0d beats seen",
                          cycle_count, beats_seen, total_beats));
    end
    if (!rst && m_tvalid && m_tready) begin
      assert (exp_q.size() != 0) else
        abort_run("an output beat arrived after all expected beats were seen");
      expected = exp_q.pop_front();
      actual   = {m_tuser, m_tlast, m_tkeep, m_tdata};
      assert (actual === expected) else
        abort_run($sformatf("Error at %0t: beat %0d got %s, expected %s", $time,
                            beats_seen, describe_beat(actual), describe_beat(expected)));
      beats_seen++;
    end
  end

  initial begin
    int   idx;
    logic ready_seen;
    s_tdata     = '0;
    s_tkeep     = '0;
    s_tvalid    = 1'b0;
    s_tlast     = 1'b0;
    s_tuser     = 1'b0;
    m_tready    = 1'b0;
    lfsr_state  = lfsr_seed;
    calm_words  = 0;
    calm_beats  = 0;
    beats_seen  = 0;
    cycle_count = 0;
    build_frames();

    repeat (reset_cycles) begin
      @(negedge clk);
      assert (!s_tready && !m_tvalid) else
        abort_run($sformatf("Error at %0t: s_tready %b m_tvalid %b while in reset",
                            $time, s_tready, m_tvalid));
    end

    // s_tready is registered, so its value at the falling edge holds through the next rise
    idx        = 0;
    ready_seen = 1'b0;
    while (idx < word_data_q.size() || exp_q.size() != 0) begin
      @(negedge clk);
      if (s_tvalid && ready_seen) begin
        idx++;
        s_tvalid = 1'b0;
      end
      if (!s_tvalid && idx < word_data_q.size()) begin
        if (idx < calm_words || random_bits(2) != 0) begin
          s_tdata  = word_data_q[idx];
          s_tkeep  = word_keep_q[idx];
          s_tlast  = word_last_q[idx];
          s_tuser  = word_user_q[idx];
          s_tvalid = 1'b1;
        end
      end
      if (beats_seen < calm_beats) begin
        m_tready = 1'b1;
      end else begin
        m_tready = random_bits(2) != 0;
      end
      ready_seen = s_tready;
    end

    // any beat still stuck in a skid buffer shows up here as an extra beat
    m_tready = 1'b1;
    repeat (drain_cycles) @(negedge clk);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: stream_resizer.f
source/stream_geometry_pkg.sv
source/adapter_state_pkg.sv
source/axis_skid_buffer.sv
source/axis_downsizer.sv
source/axis_upsizer.sv
source/stream_resizer.sv
verification/tb_clock_gen.sv
verification/stream_resizer_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench and RTL with Verilator, then run; a failing run exits nonzero
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module stream_resizer_tb -f stream_resizer.f -o stream_resizer_sim &&
./obj_dir/stream_resizer_sim || exit 1
